// File: display_select.sv
`default_nettype none

module display_select (
    input  wire                      clk,
    input  wire                      reset,
    input  wire panel_pkg::panel_cmd_t cmd,
    output panel_pkg::dsel_vec_t     dsel,
    output panel_pkg::led_vec_t      dsel_led
);

    logic trig_q;
    logic step;

    // one step per press group, taken on the first trigger cycle
    always_comb
    begin
        step = cmd.trigger & ~trig_q & cmd.keys[panel_pkg::KEY_DSEL];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_q <= 1'b0;
            dsel   <= panel_pkg::DSEL_RESET;
        end
        else
        begin
            trig_q <= cmd.trigger;
            if (step)
            begin
                // rotate right, wrapping the low bit back to the top
                dsel <= {dsel[0], dsel[5:1]};
            end
        end
    end

    // two LED groups of two and three lamps show the selected position
    always_comb
    begin
        case (dsel)
            6'b100000: dsel_led = 5'b01100;
            6'b010000: dsel_led = 5'b01010;
            6'b001000: dsel_led = 5'b01001;
            6'b000100: dsel_led = 5'b10100;
            6'b000010: dsel_led = 5'b10010;
            6'b000001: dsel_led = 5'b10001;
            default:   dsel_led = 5'b01100;
        endcase
    end

endmodule

`default_nettype wire

// File: front_panel_checker.sv
`default_nettype none

module front_panel_checker (
    input wire                        clk,
    input wire                        reset,
    input wire panel_pkg::panel_cmd_t cmd,
    input wire                        busy,
    input wire panel_pkg::dsel_vec_t  dsel
);

    // the debounce lockout never overlaps the command pulses
    a_cmd_quiet_when_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> cmd == '0)
        else $error("cmd is not zero while busy is high");

    a_dsel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(dsel))
        else $error("display selector is not one-hot");

    // each accepted group holds its command pulses for exactly three cycles
    a_trigger_three_cycles: assert property (@(posedge clk) disable iff (reset)
        $fell(cmd.trigger) |-> $past(cmd.trigger, 2) && $past(cmd.trigger, 3)
                               && !$past(cmd.trigger, 4))
        else $error("command trigger did not last three cycles");

endmodule

bind front_panel_top front_panel_checker u_front_panel_checker (
    .clk   (clk),
    .reset (reset),
    .cmd   (cmd),
    .busy  (busy),
    .dsel  (dsel)
);

`default_nettype wire

// File: front_panel_tb.sv
`default_nettype none

module front_panel_tb;

    logic                  clk;
    logic                  reset;
    panel_pkg::key_vec_t   keys;
    panel_pkg::apb_req_t   apb_req;
    panel_pkg::apb_rsp_t   apb_rsp;
    panel_pkg::panel_cmd_t cmd;
    logic                  busy;
    panel_pkg::dsel_vec_t  dsel;
    panel_pkg::led_vec_t   dsel_led;

    string       op_q[$];
    logic [31:0] arg_q[$];
    int          hold_q[$];
    logic [31:0] ev_q[$];
    logic [31:0] sel_q[$];
    logic [31:0] cnt_q[$];
    int          errors = 0;
    int          limit_cycles = 0;

    // reference model of what the processor should see over APB
    panel_pkg::key_vec_t  mask_m;
    panel_pkg::key_vec_t  event_m;
    panel_pkg::dsel_vec_t dsel_m;
    panel_pkg::count_t    count_m;

    front_panel_top u_front_panel_top (
        .clk      (clk),
        .reset    (reset),
        .keys     (keys),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .cmd      (cmd),
        .busy     (busy),
        .dsel     (dsel),
        .dsel_led (dsel_led)
    );

    always #10 clk = ~clk;

    // two lamps name the half of the selector and three lamps the position inside it
    function automatic panel_pkg::led_vec_t expected_led(input panel_pkg::dsel_vec_t sel);
        if ($onehot(sel) && sel[2:0] != 3'b000)
        begin
            return {2'b10, sel[2:0]};
        end
        return {2'b01, $onehot(sel) ? sel[5:3] : 3'b100};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic apb_xfer(input logic wr, input panel_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // read data is combinational during the access phase
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_val("pready", 32'h1, 32'(apb_rsp.pready));
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic read_reg(input panel_pkg::apb_addr_t addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        if (err)
        begin
            errors++;
            $display("read of register %h answered with a slave error", addr);
        end
    endtask

    task automatic poll_busy(input logic want, input int tries, output logic seen);
        logic [31:0] status;
        seen = 1'b0;
        for (int i = 0; i < tries && !seen; i++)
        begin
            read_reg(panel_pkg::REG_STATUS, status);
            seen = (status[panel_pkg::STATUS_BUSY_BIT] == want);
        end
    endtask

    // the command pulses carry the accepted keys for three cycles, then the lockout starts
    task automatic check_cmd(input panel_pkg::key_vec_t want);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!cmd.trigger && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (!cmd.trigger)
        begin
            errors++;
            $display("command trigger never rose for keys %h", want);
        end
        else
        begin
            for (int c = 0; c < 3; c++)
            begin
                check_val("cmd.trigger", 32'h1, 32'(cmd.trigger));
                check_val("cmd.keys", 32'(want), 32'(cmd.keys));
                @(negedge clk);
            end
            check_val("cmd", 32'h0, 32'(cmd));
            check_val("busy", 32'h1, 32'(busy));
        end
    endtask

    task automatic check_regs;
        logic [31:0] data;
        read_reg(panel_pkg::REG_EVENT, data);
        check_val("REG_EVENT", 32'(event_m), data);
        event_m = '0;
        read_reg(panel_pkg::REG_EVENT, data);
        check_val("REG_EVENT reread", 32'h0, data);
        read_reg(panel_pkg::REG_MASK, data);
        check_val("REG_MASK", 32'(mask_m), data);
        read_reg(panel_pkg::REG_COUNT, data);
        check_val("REG_COUNT", 32'(count_m), data);
        read_reg(panel_pkg::REG_STATUS, data);
        check_val("REG_STATUS", 32'(dsel_m), data);
        @(negedge clk);
        check_val("dsel_led", 32'(expected_led(dsel_m)), 32'(dsel_led));
        check_val("dsel", 32'(dsel_m), 32'(dsel));
        check_val("busy", 32'h0, 32'(busy));
        check_val("cmd", 32'h0, 32'(cmd));
    endtask

    initial
    begin
        int                  fd;
        int                  n;
        int                  hold;
        string               line;
        string               op;
        logic [31:0]         arg;
        logic [31:0]         ev;
        logic [31:0]         sel;
        logic [31:0]         cnt;
        logic [31:0]         data;
        logic                err;
        logic                seen;
        panel_pkg::key_vec_t acc;
        clk     = 1'b0;
        reset   = 1'b1;
        keys    = '0;
        apb_req = '0;
        mask_m  = '1;
        event_m = '0;
        dsel_m  = panel_pkg::DSEL_RESET;
        count_m = '0;
        fd = $fopen("panel_input.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the stimulus file panel_input.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#")
                begin
                    continue;
                end
                n = $sscanf(line, "%s %h %d %h %h %h", op, arg, hold, ev, sel, cnt);
                if (n == 6)
                begin
                    op_q.push_back(op);
                    arg_q.push_back(arg);
                    hold_q.push_back(hold);
                    ev_q.push_back(ev);
                    sel_q.push_back(sel);
                    cnt_q.push_back(cnt);
                end
                else if (n > 0)
                begin
                    errors++;
                    $display("malformed stimulus line: %s", line);
                end
            end
            $fclose(fd);
        end
        limit_cycles = (op_q.size() + 2) * 200;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < op_q.size(); i++)
        begin
            if (op_q[i] == "press")
            begin
                poll_busy(1'b0, 40, seen);
                if (!seen)
                begin
                    errors++;
                    $display("panel stayed busy before press %0d", i);
                end
                acc = arg_q[i][6:0] & mask_m;
                if (acc != '0)
                begin
                    event_m = event_m | acc;
                    count_m++;
                    if (acc[panel_pkg::KEY_DSEL])
                    begin
                        // the selector steps toward the low end and wraps to the top
                        if (dsel_m == 6'b000001)
                        begin
                            dsel_m = panel_pkg::DSEL_RESET;
                        end
                        else
                        begin
                            dsel_m = dsel_m >> 1;
                        end
                    end
                end
                @(posedge clk);
                keys <= arg_q[i][6:0];
                repeat (hold_q[i]) @(posedge clk);
                keys <= '0;
                if (acc != '0)
                begin
                    check_cmd(acc);
                    poll_busy(1'b1, 40, seen);
                    if (!seen)
                    begin
                        errors++;
                        $display("busy never rose after accepted press %0d", i);
                    end
                    poll_busy(1'b0, 40, seen);
                    if (!seen)
                    begin
                        errors++;
                        $display("busy never cleared after press %0d", i);
                    end
                end
                else
                begin
                    // nothing enabled was pressed, so the panel has to stay idle
                    poll_busy(1'b1, 12, seen);
                    if (seen)
                    begin
                        errors++;
                        $display("busy rose after press %0d of masked keys only", i);
                    end
                end
            end
            else if (op_q[i] == "mask")
            begin
                apb_xfer(1'b1, panel_pkg::REG_MASK, arg_q[i], data, err);
                check_val("pslverr", 32'h0, 32'(err));
                mask_m = arg_q[i][6:0];
            end
            else if (op_q[i] == "bad")
            begin
                apb_xfer(1'b0, arg_q[i][7:0], 32'h0, data, err);
                check_val("pslverr", 32'h1, 32'(err));
                check_val("prdata", 32'h0, data);
            end
            else if (op_q[i] != "check")
            begin
                errors++;
                $display("unknown operation %s in stimulus entry %0d", op_q[i], i);
            end
            check_val("file event", ev_q[i], 32'(event_m));
            check_val("file dsel", sel_q[i], 32'(dsel_m));
            check_val("file count", cnt_q[i], 32'(count_m));
            check_regs();
        end
        $display("%0d operations run, %0d errors", op_q.size(), errors);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: front_panel_top.sv
`default_nettype none

module front_panel_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire panel_pkg::key_vec_t keys,
    input  wire panel_pkg::apb_req_t apb_req,
    output panel_pkg::apb_rsp_t      apb_rsp,
    output panel_pkg::panel_cmd_t    cmd,
    output logic                     busy,
    output panel_pkg::dsel_vec_t     dsel,
    output panel_pkg::led_vec_t      dsel_led
);

    panel_pkg::key_vec_t latched;
    panel_pkg::key_vec_t mask;
    logic                capture_en;
    logic                flush;

    switch_capture u_switch_capture (
        .clk        (clk),
        .reset      (reset),
        .keys       (keys),
        .mask       (mask),
        .capture_en (capture_en),
        .flush      (flush),
        .latched    (latched)
    );

    // the sequencer owns the command pulses and the lockout
    panel_sequencer u_panel_sequencer (
        .clk        (clk),
        .reset      (reset),
        .latched    (latched),
        .capture_en (capture_en),
        .flush      (flush),
        .cmd        (cmd),
        .busy       (busy)
    );

    display_select u_display_select (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .dsel     (dsel),
        .dsel_led (dsel_led)
    );

    panel_apb_regs u_panel_apb_regs (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cmd     (cmd),
        .dsel    (dsel),
        .busy    (busy),
        .mask    (mask)
    );

endmodule

`default_nettype wire

// File: panel_apb_regs.sv
`default_nettype none

module panel_apb_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire panel_pkg::apb_req_t apb_req,
    output panel_pkg::apb_rsp_t      apb_rsp,
    input  wire panel_pkg::panel_cmd_t cmd,
    input  wire panel_pkg::dsel_vec_t  dsel,
    input  wire                      busy,
    output panel_pkg::key_vec_t      mask
);

    logic                 trig_q;
    logic                 trig_rise;
    logic                 access;
    logic                 rd_en;
    logic                 wr_en;
    logic                 addr_hit;
    panel_pkg::apb_data_t rd_data;
    panel_pkg::key_vec_t  event_q;
    panel_pkg::key_vec_t  mask_q;
    panel_pkg::count_t    count_q;

    always_comb
    begin
        trig_rise = cmd.trigger & ~trig_q;
        access    = apb_req.psel & apb_req.penable;
        rd_en     = access & ~apb_req.pwrite;
        wr_en     = access & apb_req.pwrite;
    end

    // register decode, unmapped addresses answer with an error
    always_comb
    begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (apb_req.paddr)
            panel_pkg::REG_EVENT:  rd_data = panel_pkg::apb_data_t'(event_q);
            panel_pkg::REG_MASK:   rd_data = panel_pkg::apb_data_t'(mask_q);
            panel_pkg::REG_STATUS:
            begin
                rd_data[5:0]                      = dsel;
                rd_data[panel_pkg::STATUS_BUSY_BIT] = busy;
            end
            panel_pkg::REG_COUNT:  rd_data = panel_pkg::apb_data_t'(count_q);
            default:               addr_hit = 1'b0;
        endcase
    end

    always_comb
    begin
        apb_rsp.prdata  = (rd_en && addr_hit) ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~addr_hit;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_q  <= 1'b0;
            event_q <= '0;
            mask_q  <= '1;
            count_q <= '0;
        end
        else
        begin
            trig_q <= cmd.trigger;
            if (wr_en && apb_req.paddr == panel_pkg::REG_MASK)
            begin
                mask_q <= apb_req.pwdata[panel_pkg::KEY_W-1:0];
            end
            // a read clears the events, but bits arriving in the same cycle stay
            event_q <= ((rd_en && apb_req.paddr == panel_pkg::REG_EVENT) ? '0 : event_q)
                       | (trig_rise ? cmd.keys : '0);
            if (trig_rise)
            begin
                count_q <= count_q + panel_pkg::count_t'(1);
            end
        end
    end

    assign mask = mask_q;

endmodule

`default_nettype wire

// File: panel_input.txt
# columns are op, key or mask value, hold cycles, expected event, dsel and count
# ops are press, mask, bad and check, and every value except hold is hex
check 00 0 00 20 0000
press 40 2 40 20 0001
press 08 3 08 20 0002
press 06 2 06 20 0003
press 01 2 01 10 0004
press 01 2 01 08 0005
press 01 3 01 04 0006
press 01 2 01 02 0007
press 01 2 01 01 0008
press 01 2 01 20 0009
mask 7d 0 00 20 0009
press 02 2 00 20 0009
press 0a 2 08 20 000a
bad 10 0 00 20 000a
mask 7f 0 00 20 000a
press 02 2 02 20 000b
check 00 0 00 20 000b

// File: panel_pkg.sv
`default_nettype none

package panel_pkg;

    // panel keys, from the high bit down: clear, extd_addr, addr_load, dep, exam, cont, dsel
    localparam int KEY_W = 7;
    localparam int KEY_DSEL = 0;

    typedef logic [KEY_W-1:0] key_vec_t;

    // one command pulse set, held for three cycles per accepted press group
    typedef struct packed {
        logic     trigger;
        key_vec_t keys;
    } panel_cmd_t;

    typedef logic [5:0] dsel_vec_t;
    typedef logic [4:0] led_vec_t;

    // the selector comes out of reset on its top position
    localparam dsel_vec_t DSEL_RESET = 6'b100000;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [15:0] count_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    localparam apb_addr_t REG_EVENT  = 8'h00;
    localparam apb_addr_t REG_MASK   = 8'h04;
    localparam apb_addr_t REG_STATUS = 8'h08;
    localparam apb_addr_t REG_COUNT  = 8'h0C;
    localparam int STATUS_BUSY_BIT = 8;

    // the lockout lasts 2**DBNCE_BITS cycles, kept short for simulation
    localparam int DBNCE_BITS = 4;
    typedef logic [DBNCE_BITS:0] dbnce_cnt_t;

    typedef enum logic [2:0] {
        LATCH,
        WAIT,
        TRIG1,
        TRIG2,
        TRIG3,
        DELAY,
        REENABLE
    } seq_state_t;

endpackage

`default_nettype wire

// File: panel_sequencer.sv
`default_nettype none

module panel_sequencer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire panel_pkg::key_vec_t latched,
    output logic                  capture_en,
    output logic                  flush,
    output panel_pkg::panel_cmd_t cmd,
    output logic                  busy
);

    panel_pkg::seq_state_t state;
    panel_pkg::dbnce_cnt_t dbnce_cnt;
    panel_pkg::dbnce_cnt_t dbnce_next;

    // the lockout ends when the next count reaches 2**DBNCE_BITS,
    // which gives exactly that many cycles in DELAY
    always_comb
    begin
        dbnce_next = dbnce_cnt + panel_pkg::dbnce_cnt_t'(1);
    end

    // keys are only accepted while idle, everything later is lost
    always_comb
    begin
        capture_en = (state == panel_pkg::LATCH);
        flush      = (state == panel_pkg::WAIT);
        busy       = (state == panel_pkg::DELAY);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= panel_pkg::LATCH;
            cmd       <= '0;
            dbnce_cnt <= '0;
        end
        else
        begin
            case (state)
                panel_pkg::LATCH:
                begin
                    if (latched != '0)
                    begin
                        state <= panel_pkg::WAIT;
                    end
                end
                panel_pkg::WAIT:
                begin
                    // the accumulator is flushed on this same edge
                    cmd.trigger <= 1'b1;
                    cmd.keys    <= latched;
                    state       <= panel_pkg::TRIG1;
                end
                panel_pkg::TRIG1:
                begin
                    state <= panel_pkg::TRIG2;
                end
                panel_pkg::TRIG2:
                begin
                    state <= panel_pkg::TRIG3;
                end
                panel_pkg::TRIG3:
                begin
                    // command pulses end here and the lockout starts
                    cmd       <= '0;
                    dbnce_cnt <= '0;
                    state     <= panel_pkg::DELAY;
                end
                panel_pkg::DELAY:
                begin
                    dbnce_cnt <= dbnce_next;
                    if (dbnce_next[panel_pkg::DBNCE_BITS])
                    begin
                        state <= panel_pkg::REENABLE;
                    end
                end
                panel_pkg::REENABLE:
                begin
                    state <= panel_pkg::LATCH;
                end
                default:
                begin
                    state <= panel_pkg::LATCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module front_panel_tb -f vlog.f -o front_panel_sim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/front_panel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"

// File: switch_capture.sv
`default_nettype none

module switch_capture (
    input  wire                 clk,
    input  wire                 reset,
    input  wire panel_pkg::key_vec_t keys,
    input  wire panel_pkg::key_vec_t mask,
    input  wire                 capture_en,
    input  wire                 flush,
    output panel_pkg::key_vec_t latched
);

    // two flop synchronizer for the asynchronous panel keys
    panel_pkg::key_vec_t sync_meta;
    panel_pkg::key_vec_t sync_keys;

    // keys that are masked off never reach the accumulator
    panel_pkg::key_vec_t enabled_keys;

    always_comb
    begin
        enabled_keys = sync_keys & mask;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_meta <= '0;
            sync_keys <= '0;
        end
        else
        begin
            sync_meta <= keys;
            sync_keys <= sync_meta;
        end
    end

    // presses are gathered while the sequencer is idle, so keys
    // pressed a little apart still end up in one group
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            latched <= '0;
        end
        else if (flush)
        begin
            latched <= '0;
        end
        else if (capture_en)
        begin
            latched <= latched | enabled_keys;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
panel_pkg.sv
switch_capture.sv
panel_sequencer.sv
display_select.sv
panel_apb_regs.sv
front_panel_top.sv
front_panel_checker.sv
front_panel_tb.sv
